// File: all.f
munoc_pkg.sv
munoc_req_packetizer.sv
munoc_link_buffer.sv
munoc_slave_endpoint.sv
munoc_resp_tracker.sv
munoc_master_ni_top.sv
tb_munoc_master_ni.sv

// File: munoc_link_buffer.sv
// Link buffer
// Circular flit FIFO forming one network hop, valid/ready on both sides

`timescale 1ns/1ps

module munoc_link_buffer #(
	parameter type         flit_t          = munoc_pkg::fni_flit_t,
	parameter int unsigned NUM_LINK_BUFFER = 2
) (
	input  logic  clk_network,
	input  logic  arst_n,
	input  flit_t in_link,
	input  logic  out_ready,
	output logic  in_ready,
	output flit_t out_link
);

	localparam int unsigned PTR_W = (NUM_LINK_BUFFER > 1) ? $clog2(NUM_LINK_BUFFER) : 1;
	localparam int unsigned CNT_W = $clog2(NUM_LINK_BUFFER + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	flit_t slots [NUM_LINK_BUFFER];
	ptr_t  wr_ptr;
	ptr_t  rd_ptr;
	cnt_t  count;
	logic  push;
	logic  pop;

	function automatic ptr_t next_ptr(input ptr_t ptr);
		if (ptr == ptr_t'(NUM_LINK_BUFFER - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign in_ready = (count != cnt_t'(NUM_LINK_BUFFER));
	assign push     = in_link.valid && in_ready;
	assign pop      = out_link.valid && out_ready;

	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_network) begin
		if (push) begin
			slots[wr_ptr] <= in_link;
		end
	end

	// Oldest flit offered downstream
	always_comb begin
		out_link       = slots[rd_ptr];
		out_link.valid = (count != '0);
	end

	// A flit refused by a full buffer stays offered unchanged, so nothing is lost
	a_no_write_full: assert property (
		@(posedge clk_network) disable iff (!arst_n)
		in_link.valid && !in_ready |=> in_link.valid && $stable(in_link)
	);

endmodule

// File: munoc_master_ni_top.sv
// Master network interface top level
// Packetizer, forward link, slave endpoint, backward link, response tracker

`timescale 1ns/1ps

module munoc_master_ni_top #(
	parameter munoc_pkg::node_id_t NODE_ID         = 4'd1,
	parameter int unsigned         MEM_WORDS       = 256,
	parameter int unsigned         NUM_LINK_BUFFER = 2,
	parameter int unsigned         MAX_OUTSTANDING = 2
) (
	input  logic                 clk_network,
	input  logic                 arst_n,
	input  logic                 comm_disable,
	input  logic                 rlmq_valid,
	input  munoc_pkg::rlmq_req_t rlmq_req,
	input  logic                 rlmy_ready,
	output logic                 rlmq_ready,
	output logic                 rlmy_valid,
	output munoc_pkg::data_t     rlmy_rdata,
	output logic                 rlmy_error
);

	// Forward path
	munoc_pkg::fni_flit_t fni_pkt_link;
	logic                 fni_pkt_ready;
	munoc_pkg::fni_flit_t fni_ep_link;
	logic                 fni_ep_ready;

	// Backward path
	munoc_pkg::bni_flit_t bni_ep_link;
	logic                 bni_ep_ready;
	munoc_pkg::bni_flit_t bni_trk_link;
	logic                 bni_trk_ready;

	// Credit
	logic read_credit;
	logic read_issued;

	munoc_req_packetizer munoc_req_packetizer_inst (
		.clk_network  (clk_network),
		.arst_n       (arst_n),
		.comm_disable (comm_disable),
		.rlmq_valid   (rlmq_valid),
		.rlmq_req     (rlmq_req),
		.read_credit  (read_credit),
		.fni_ready    (fni_pkt_ready),
		.rlmq_ready   (rlmq_ready),
		.fni_link     (fni_pkt_link),
		.read_issued  (read_issued)
	);

	munoc_link_buffer #(
		.flit_t          (munoc_pkg::fni_flit_t),
		.NUM_LINK_BUFFER (NUM_LINK_BUFFER)
	) fni_link_buffer_inst (
		.clk_network (clk_network),
		.arst_n      (arst_n),
		.in_link     (fni_pkt_link),
		.out_ready   (fni_ep_ready),
		.in_ready    (fni_pkt_ready),
		.out_link    (fni_ep_link)
	);

	munoc_slave_endpoint #(
		.NODE_ID   (NODE_ID),
		.MEM_WORDS (MEM_WORDS)
	) munoc_slave_endpoint_inst (
		.clk_network (clk_network),
		.arst_n      (arst_n),
		.fni_link    (fni_ep_link),
		.bni_ready   (bni_ep_ready),
		.fni_ready   (fni_ep_ready),
		.bni_link    (bni_ep_link)
	);

	munoc_link_buffer #(
		.flit_t          (munoc_pkg::bni_flit_t),
		.NUM_LINK_BUFFER (NUM_LINK_BUFFER)
	) bni_link_buffer_inst (
		.clk_network (clk_network),
		.arst_n      (arst_n),
		.in_link     (bni_ep_link),
		.out_ready   (bni_trk_ready),
		.in_ready    (bni_ep_ready),
		.out_link    (bni_trk_link)
	);

	munoc_resp_tracker #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) munoc_resp_tracker_inst (
		.clk_network (clk_network),
		.arst_n      (arst_n),
		.read_issued (read_issued),
		.bni_link    (bni_trk_link),
		.rlmy_ready  (rlmy_ready),
		.read_credit (read_credit),
		.bni_ready   (bni_trk_ready),
		.rlmy_valid  (rlmy_valid),
		.rlmy_rdata  (rlmy_rdata),
		.rlmy_error  (rlmy_error)
	);

endmodule

// File: munoc_pkg.sv
// Shared definitions for the master network interface
// Address, data, permit and node widths
// Forward and backward flit structs, flit kind enum
// Master request struct and address field helpers

package munoc_pkg;

	// ****************************************
	// Widths
	// ****************************************

	// Platform byte address
	typedef logic [31:0] addr_t;

	// Node data word
	typedef logic [31:0] data_t;

	// One write permit per byte of data_t
	typedef logic [3:0] permit_t;

	// Network node number
	typedef logic [3:0] node_id_t;

	// Word index inside a node
	typedef logic [25:0] word_addr_t;

	// Address fields
	localparam int unsigned NODE_MSB = 31;
	localparam int unsigned NODE_LSB = 28;
	localparam int unsigned WORD_MSB = 27;
	localparam int unsigned WORD_LSB = 2;

	// ****************************************
	// Flits
	// ****************************************

	typedef enum logic [1:0] {
		head_read,
		head_write,
		write_data,
		read_resp
	} flit_kind_t;

	// Forward flit, master side to slave side
	// Payload is the address on a head flit and the write data on a data flit
	typedef struct packed {
		logic       valid;
		flit_kind_t kind;
		node_id_t   dest;
		permit_t    permit;
		data_t      payload;
	} fni_flit_t;

	// Backward flit carrying read data
	typedef struct packed {
		logic  valid;
		logic  error;
		data_t payload;
	} bni_flit_t;

	// One request from the local master
	typedef struct packed {
		addr_t   addr;
		logic    write;
		data_t   wdata;
		permit_t permit;
	} rlmq_req_t;

	// Destination node of an address
	function automatic node_id_t addr_node(input addr_t addr);
		return addr[NODE_MSB:NODE_LSB];
	endfunction

	// Word index of an address
	function automatic word_addr_t addr_word(input addr_t addr);
		return addr[WORD_MSB:WORD_LSB];
	endfunction

endpackage

// File: munoc_req_packetizer.sv
// Request packetizer
// Accepts master requests under credit and comm_disable control
// Emits one head flit per request and one data flit per write

`timescale 1ns/1ps

module munoc_req_packetizer (
	input  logic                 clk_network,
	input  logic                 arst_n,
	input  logic                 comm_disable,
	input  logic                 rlmq_valid,
	input  munoc_pkg::rlmq_req_t rlmq_req,
	input  logic                 read_credit,
	input  logic                 fni_ready,
	output logic                 rlmq_ready,
	output munoc_pkg::fni_flit_t fni_link,
	output logic                 read_issued
);

	typedef enum logic {
		send_head,
		send_data
	} pkt_state_t;

	pkt_state_t           state;
	logic                 flit_valid;
	munoc_pkg::fni_flit_t flit_q;
	munoc_pkg::data_t     wdata_q;
	munoc_pkg::permit_t   permit_q;
	logic                 idle;
	logic                 accept;
	logic                 flit_fire;

	// Reads need a free credit, writes are posted
	assign idle        = (state == send_head) && !flit_valid;
	assign rlmq_ready  = idle && !comm_disable && (read_credit || rlmq_req.write);
	assign accept      = rlmq_valid && rlmq_ready;
	assign read_issued = accept && !rlmq_req.write;
	assign flit_fire   = flit_valid && fni_ready;

	// ****************************************
	// FSM
	// ****************************************

	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			state      <= send_head;
			flit_valid <= 1'b0;
		end else if (accept) begin
			flit_valid <= 1'b1;
			if (rlmq_req.write) begin
				state <= send_data;
			end else begin
				state <= send_head;
			end
		end else if (flit_fire) begin
			// A write head is replaced by its data flit, anything else ends the request
			if (flit_q.kind != munoc_pkg::head_write) begin
				flit_valid <= 1'b0;
				state      <= send_head;
			end
		end
	end

	// Flit and request payload
	always_ff @(posedge clk_network) begin
		if (accept) begin
			flit_q.valid   <= 1'b1;
			flit_q.dest    <= munoc_pkg::addr_node(rlmq_req.addr);
			flit_q.permit  <= '0;
			flit_q.payload <= rlmq_req.addr;
			if (rlmq_req.write) begin
				flit_q.kind <= munoc_pkg::head_write;
			end else begin
				flit_q.kind <= munoc_pkg::head_read;
			end
			wdata_q  <= rlmq_req.wdata;
			permit_q <= rlmq_req.permit;
		end else if (flit_fire && (flit_q.kind == munoc_pkg::head_write)) begin
			flit_q.kind    <= munoc_pkg::write_data;
			flit_q.permit  <= permit_q;
			flit_q.payload <= wdata_q;
		end
	end

	always_comb begin
		fni_link       = flit_q;
		fni_link.valid = flit_valid;
	end

	// Offered flit holds until the forward link takes it
	a_fni_stable: assert property (
		@(posedge clk_network) disable iff (!arst_n)
		fni_link.valid && !fni_ready |=> fni_link.valid && $stable(fni_link)
	);

endmodule

// File: munoc_resp_tracker.sv
// Response tracker
// Outstanding read count and read credit
// Presents backward flits to the master as rlmy

`timescale 1ns/1ps

module munoc_resp_tracker #(
	parameter int unsigned MAX_OUTSTANDING = 2
) (
	input  logic                 clk_network,
	input  logic                 arst_n,
	input  logic                 read_issued,
	input  munoc_pkg::bni_flit_t bni_link,
	input  logic                 rlmy_ready,
	output logic                 read_credit,
	output logic                 bni_ready,
	output logic                 rlmy_valid,
	output munoc_pkg::data_t     rlmy_rdata,
	output logic                 rlmy_error
);

	localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

	typedef logic [CNT_W-1:0] count_t;

	count_t outstanding;
	logic   resp_fire;

	// Head of the backward buffer goes straight to the master
	assign rlmy_valid = bni_link.valid;
	assign rlmy_rdata = bni_link.payload;
	assign rlmy_error = bni_link.error;
	assign bni_ready  = rlmy_ready;
	assign resp_fire  = rlmy_valid && rlmy_ready;

	assign read_credit = (outstanding < count_t'(MAX_OUTSTANDING));

	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			outstanding <= '0;
		end else if (read_issued && !resp_fire) begin
			outstanding <= outstanding + 1'b1;
		end else if (resp_fire && !read_issued) begin
			outstanding <= outstanding - 1'b1;
		end
	end

	// Packetizer honours the credit
	a_no_overflow: assert property (
		@(posedge clk_network) disable iff (!arst_n)
		outstanding <= count_t'(MAX_OUTSTANDING)
	);

	// No response without a read in flight
	a_no_underflow: assert property (
		@(posedge clk_network) disable iff (!arst_n)
		resp_fire && !read_issued |-> outstanding != '0
	);

endmodule

// File: munoc_slave_endpoint.sv
// Slave endpoint
// Depacketizes forward flits and checks the destination node
// Word memory with byte write permits, read response flits

`timescale 1ns/1ps

module munoc_slave_endpoint #(
	parameter munoc_pkg::node_id_t NODE_ID   = 4'd1,
	parameter int unsigned         MEM_WORDS = 256
) (
	input  logic                 clk_network,
	input  logic                 arst_n,
	input  munoc_pkg::fni_flit_t fni_link,
	input  logic                 bni_ready,
	output logic                 fni_ready,
	output munoc_pkg::bni_flit_t bni_link
);

	localparam int unsigned IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int unsigned NUM_BYTES = $bits(munoc_pkg::permit_t);

	typedef logic [IDX_W-1:0] mem_idx_t;

	munoc_pkg::data_t mem [MEM_WORDS];
	logic             fni_fire;
	logic             node_match;
	mem_idx_t         flit_idx;
	mem_idx_t         wr_idx;
	logic             wr_pending;
	logic             resp_valid;
	logic             resp_error;
	munoc_pkg::data_t resp_data;

	// Stall intake only while a response sits on a blocked backward link
	assign fni_ready  = !(resp_valid && !bni_ready);
	assign fni_fire   = fni_link.valid && fni_ready;
	assign node_match = (fni_link.dest == NODE_ID);
	assign flit_idx   = mem_idx_t'(munoc_pkg::addr_word(fni_link.payload) % MEM_WORDS);

	// ****************************************
	// Write path
	// ****************************************

	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			wr_pending <= 1'b0;
		end else if (fni_fire) begin
			if (fni_link.kind == munoc_pkg::head_write) begin
				wr_pending <= 1'b1;
			end else if (fni_link.kind == munoc_pkg::write_data) begin
				wr_pending <= 1'b0;
			end
		end
	end

	// Word index held from the head until the data flit
	always_ff @(posedge clk_network) begin
		if (fni_fire && (fni_link.kind == munoc_pkg::head_write)) begin
			wr_idx <= flit_idx;
		end
	end

	// Writes to another node are dropped
	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			for (int w = 0; w < MEM_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else if (fni_fire && (fni_link.kind == munoc_pkg::write_data) && node_match) begin
			for (int b = 0; b < NUM_BYTES; b++) begin
				if (fni_link.permit[b]) begin
					mem[wr_idx][8*b +: 8] <= fni_link.payload[8*b +: 8];
				end
			end
		end
	end

	// ****************************************
	// Read path
	// ****************************************

	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			resp_valid <= 1'b0;
		end else if (fni_fire && (fni_link.kind == munoc_pkg::head_read)) begin
			resp_valid <= 1'b1;
		end else if (bni_ready) begin
			resp_valid <= 1'b0;
		end
	end

	// Wrong node reads return zero with error
	always_ff @(posedge clk_network) begin
		if (fni_fire && (fni_link.kind == munoc_pkg::head_read)) begin
			resp_error <= !node_match;
			if (node_match) begin
				resp_data <= mem[flit_idx];
			end else begin
				resp_data <= '0;
			end
		end
	end

	always_comb begin
		bni_link.valid   = resp_valid;
		bni_link.error   = resp_error;
		bni_link.payload = resp_data;
	end

	// Every data flit follows its own write head
	a_data_after_head: assert property (
		@(posedge clk_network) disable iff (!arst_n)
		fni_fire && (fni_link.kind == munoc_pkg::write_data) |-> wr_pending
	);

	// A blocked response keeps its data
	a_resp_stable: assert property (
		@(posedge clk_network) disable iff (!arst_n)
		resp_valid && !bni_ready |=> resp_valid && $stable(bni_link)
	);

endmodule

// File: run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_munoc_master_ni -f all.f -o tb_sim \
	> build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Verification failed" sim.log \
	&& { echo "Simulation reported a failure, see sim.log"; exit 1; } \
	|| { echo "Simulation finished without failures"; exit 0; }

// File: tb_munoc_master_ni.sv
// Directed testbench for the master network interface
// Reference memory model with byte permits and node check
// Request tasks, response collector, checker and watchdog

`timescale 1ns/1ps

module tb_munoc_master_ni;

	localparam munoc_pkg::node_id_t NODE_ID = 4'd1;
	localparam int MEM_WORDS = 256;
	localparam int TOTAL_REQS = 60;
	localparam int WATCHDOG_CYCLES = TOTAL_REQS * 200 + 1000;

	logic                 clk_network;
	logic                 arst_n;
	logic                 comm_disable;
	logic                 rlmq_valid;
	munoc_pkg::rlmq_req_t rlmq_req;
	logic                 rlmq_ready;
	logic                 rlmy_valid;
	munoc_pkg::data_t     rlmy_rdata;
	logic                 rlmy_error;
	logic                 rlmy_ready;

	munoc_pkg::data_t model [MEM_WORDS];
	logic [32:0]      exp_q [$];
	logic [1:0]       stall_mode;
	logic [31:0]      rand_state;
	logic [31:0]      stall_state;
	int               errors;
	int               checks;

	munoc_master_ni_top #(
		.NODE_ID (NODE_ID)
	) munoc_master_ni_top_inst (
		.clk_network  (clk_network),
		.arst_n       (arst_n),
		.comm_disable (comm_disable),
		.rlmq_valid   (rlmq_valid),
		.rlmq_req     (rlmq_req),
		.rlmy_ready   (rlmy_ready),
		.rlmq_ready   (rlmq_ready),
		.rlmy_valid   (rlmy_valid),
		.rlmy_rdata   (rlmy_rdata),
		.rlmy_error   (rlmy_error)
	);

	initial begin : clock_gen
		clk_network = 1'b0;
		forever #10 clk_network = ~clk_network;
	end

	// ****************************************
	// Helpers and reference model
	// ****************************************

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rand_state = xorshift32(rand_state);
		return rand_state;
	endfunction

	// Node in bits 31..28, word in bits 27..2
	function automatic munoc_pkg::addr_t make_addr(input munoc_pkg::node_id_t node, input int word);
		munoc_pkg::addr_t a;
		a = '0;
		a[31:28] = node;
		a[27:2] = 26'(word);
		return a;
	endfunction

	function automatic int model_idx(input munoc_pkg::addr_t addr);
		return int'(addr[27:2]) % MEM_WORDS;
	endfunction

	// Writes to another node leave the memory alone
	task automatic model_write(input munoc_pkg::addr_t addr, input munoc_pkg::data_t wdata,
			input munoc_pkg::permit_t permit);
		int idx;
		idx = model_idx(addr);
		if (addr[31:28] == NODE_ID) begin
			for (int b = 0; b < 4; b++) begin
				if (permit[b]) begin
					model[idx][8*b +: 8] = wdata[8*b +: 8];
				end
			end
		end
	endtask

	// Expected response as {error, data}
	function automatic logic [32:0] model_expect(input munoc_pkg::addr_t addr);
		if (addr[31:28] != NODE_ID) begin
			return {1'b1, 32'h0};
		end
		return {1'b0, model[model_idx(addr)]};
	endfunction

	task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// ****************************************
	// Request and response tasks
	// ****************************************

	task automatic start_req(input munoc_pkg::addr_t addr, input logic write,
			input munoc_pkg::data_t wdata, input munoc_pkg::permit_t permit);
		munoc_pkg::rlmq_req_t req;
		req.addr = addr;
		req.write = write;
		req.wdata = wdata;
		req.permit = permit;
		@(posedge clk_network);
		rlmq_req <= req;
		rlmq_valid <= 1'b1;
	endtask

	// Transfer happens on the edge after a negedge that shows ready
	task automatic wait_accept();
		@(negedge clk_network);
		while (!rlmq_ready) begin
			@(negedge clk_network);
		end
		if (rlmq_req.write) begin
			model_write(rlmq_req.addr, rlmq_req.wdata, rlmq_req.permit);
		end else begin
			exp_q.push_back(model_expect(rlmq_req.addr));
		end
		@(posedge clk_network);
		rlmq_valid <= 1'b0;
	endtask

	task automatic do_write(input munoc_pkg::addr_t addr, input munoc_pkg::data_t wdata,
			input munoc_pkg::permit_t permit);
		start_req(addr, 1'b1, wdata, permit);
		wait_accept();
	endtask

	task automatic do_read(input munoc_pkg::addr_t addr);
		start_req(addr, 1'b0, '0, '0);
		wait_accept();
	endtask

	task automatic get_resp();
		logic [32:0] want;
		@(negedge clk_network);
		while (!(rlmy_valid && rlmy_ready)) begin
			@(negedge clk_network);
		end
		if (exp_q.size() == 0) begin
			$display("Error at %0t: read response arrived with no read outstanding", $time);
			errors++;
		end else begin
			want = exp_q.pop_front();
			check("rlmy_error", 32'(rlmy_error), 32'(want[32]));
			check("rlmy_rdata", rlmy_rdata, want[31:0]);
		end
	endtask

	task automatic drain_resp();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 500) begin
			@(negedge clk_network);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Error at %0t: %0d read responses never arrived", $time, exp_q.size());
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int base_errors);
		$display("Test %s finished with %0d errors", name, errors - base_errors);
	endtask

	initial begin : resp_collector
		forever get_resp();
	end

	// 0 always ready, 1 held low, 2 random stalls
	initial begin : ready_driver
		forever begin
			@(posedge clk_network);
			case (stall_mode)
				2'd0: rlmy_ready <= 1'b1;
				2'd1: rlmy_ready <= 1'b0;
				default: begin
					stall_state = xorshift32(stall_state);
					rlmy_ready <= (stall_state[1:0] != 2'b00);
				end
			endcase
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_network);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

	// ****************************************
	// Tests
	// ****************************************

	task automatic test_write_read();
		int base;
		base = errors;
		for (int i = 0; i < 4; i++) begin
			do_write(make_addr(NODE_ID, 16 + i), next_rand(), 4'hf);
		end
		for (int i = 0; i < 4; i++) begin
			do_read(make_addr(NODE_ID, 16 + i));
		end
		drain_resp();
		end_test("write_read", base);
	endtask

	task automatic test_byte_permits();
		int base;
		base = errors;
		do_write(make_addr(NODE_ID, 20), 32'ha5a5_5a5a, 4'hf);
		do_write(make_addr(NODE_ID, 20), next_rand(), 4'b0001);
		do_write(make_addr(NODE_ID, 20), next_rand(), 4'b0110);
		do_write(make_addr(NODE_ID, 20), next_rand(), 4'b1000);
		do_read(make_addr(NODE_ID, 20));
		drain_resp();
		end_test("byte_permits", base);
	endtask

	task automatic test_wrong_node();
		int base;
		base = errors;
		do_read(make_addr(4'd2, 16));
		do_write(make_addr(4'd2, 16), next_rand(), 4'hf);
		do_read(make_addr(NODE_ID, 16));
		drain_resp();
		end_test("wrong_node", base);
	endtask

	task automatic test_backpressure();
		int          base;
		int          waited;
		logic [32:0] first_exp;
		base = errors;
		@(posedge clk_network);
		stall_mode <= 2'd1;
		repeat (2) @(posedge clk_network);
		do_read(make_addr(NODE_ID, 17));
		do_read(make_addr(NODE_ID, 18));
		// Third read must wait for a credit
		start_req(make_addr(NODE_ID, 19), 1'b0, '0, '0);
		@(negedge clk_network);
		check("rlmq_ready", 32'(rlmq_ready), 32'h0);
		waited = 0;
		while (!rlmy_valid && waited < 50) begin
			@(negedge clk_network);
			waited++;
		end
		if (!rlmy_valid) begin
			$display("Error at %0t: no read response appeared while stalled", $time);
			errors++;
		end
		first_exp = exp_q[0];
		repeat (10) begin
			@(negedge clk_network);
			check("rlmq_ready", 32'(rlmq_ready), 32'h0);
			check("rlmy_valid", 32'(rlmy_valid), 32'h1);
			check("rlmy_rdata", rlmy_rdata, first_exp[31:0]);
		end
		@(posedge clk_network);
		stall_mode <= 2'd0;
		wait_accept();
		drain_resp();
		end_test("backpressure", base);
	endtask

	task automatic test_comm_disable();
		int base;
		base = errors;
		@(posedge clk_network);
		comm_disable <= 1'b1;
		start_req(make_addr(NODE_ID, 20), 1'b0, '0, '0);
		repeat (20) begin
			@(negedge clk_network);
			check("rlmq_ready", 32'(rlmq_ready), 32'h0);
			check("rlmy_valid", 32'(rlmy_valid), 32'h0);
		end
		@(posedge clk_network);
		comm_disable <= 1'b0;
		wait_accept();
		drain_resp();
		end_test("comm_disable", base);
	endtask

	task automatic test_random();
		int          base;
		logic [31:0] r;
		base = errors;
		@(posedge clk_network);
		stall_mode <= 2'd2;
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			if (r[3]) begin
				do_write(make_addr(NODE_ID, 32 + int'(r[2:0])), next_rand(), r[7:4]);
			end else begin
				do_read(make_addr(NODE_ID, 32 + int'(r[2:0])));
			end
		end
		drain_resp();
		@(posedge clk_network);
		stall_mode <= 2'd0;
		end_test("random", base);
	endtask

	initial begin : main_seq
		$timeformat(-9, 0, " ns", 0);
		arst_n = 1'b0;
		comm_disable = 1'b0;
		rlmq_valid = 1'b0;
		rlmq_req = '0;
		rlmy_ready = 1'b0;
		stall_mode = 2'd0;
		rand_state = 32'hdad6;
		stall_state = 32'hdad6;
		errors = 0;
		checks = 0;
		for (int w = 0; w < MEM_WORDS; w++) begin
			model[w] = '0;
		end
		repeat (5) @(posedge clk_network);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk_network);
		@(negedge clk_network);
		check("rlmy_valid", 32'(rlmy_valid), 32'h0);

		test_write_read();
		test_byte_permits();
		test_wrong_node();
		test_backpressure();
		test_comm_disable();
		test_random();

		repeat (5) @(posedge clk_network);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
